// ==== Makefile ====
# Verilator build and run for the port 0 host pipe testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_host
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+logic
logic/cnn_host_pkg.sv
logic/pipe_fifo.sv
logic/pipe_in_path.sv
logic/pipe_out_path.sv
logic/port0_mover.sv
logic/cnn_host_top.sv
tb/tb_cnn_host_checker.sv
tb/tb_cnn_host.sv

// ==== logic/cnn_host_defines.svh ====
`ifndef CNN_HOST_DEFINES_SVH
`define CNN_HOST_DEFINES_SVH

// ----------------------------------------------------------------------
// port 0 host pipe sizing
// ----------------------------------------------------------------------

`define CNN_WORD_W          32    // host pipe word
`define CNN_COUNT_W         11    // wide enough for a full FIFO count

`define CNN_FIFO_SIZE       1023  // usable words, full is flagged here
`define CNN_BLOCK_SIZE      128   // 512 byte host block of 4 byte words

// margin against count latency before accepting another host block
`define CNN_BUFFER_HEADROOM 20

`endif

// ==== logic/cnn_host_pkg.sv ====
`include "cnn_host_defines.svh"

package cnn_host_pkg;

	// ----------------------------------------------------------------------
	// data and count types
	// ----------------------------------------------------------------------

	typedef logic [`CNN_WORD_W-1:0]  word_t;        // one pipe word
	typedef logic [`CNN_COUNT_W-1:0] fifo_count_t;  // FIFO occupancy

	// ----------------------------------------------------------------------
	// host control wire, bit 0 upward
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic spare;       // bit 4, not decoded
		logic engine_sel;  // bit 3, engine results feed pipe-out
		logic fifo_reset;  // bit 2, clears both FIFOs and the mover
		logic write_en;    // bit 1, pipe write, pipe-in as source
		logic move_en;     // bit 0, pipe read, enables moving to pipe-out
	} host_ctrl_t;

	// what each path reports to the mover
	typedef struct packed {
		logic        full;
		logic        empty;
		fifo_count_t count;
	} fifo_status_t;

	// ----------------------------------------------------------------------
	// mover source states
	// ----------------------------------------------------------------------

	typedef enum logic [1:0] {
		MV_IDLE   = 2'd0,  // nothing moves
		MV_PIPE   = 2'd1,  // pipe-in to pipe-out loopback
		MV_ENGINE = 2'd2   // engine stream to pipe-out
	} mover_state_e;

endpackage

// ==== logic/cnn_host_top.sv ====
`timescale 1ns/1ns

module cnn_host_top (
	input  logic                     okClk,
	input  logic                     i_arst_n,
	input  cnn_host_pkg::host_ctrl_t i_ctrl,
	input  logic                     i_pi_write,
	input  cnn_host_pkg::word_t      i_pi_data,
	output logic                     o_pi_ready,
	input  logic                     i_po_read,
	output cnn_host_pkg::word_t      o_po_data,
	output logic                     o_po_valid,
	output logic                     o_po_ready,
	input  cnn_host_pkg::word_t      i_eng_data,
	input  logic                     i_eng_valid,
	output logic                     o_eng_re,
	output logic [7:0]               o_led
);
	import cnn_host_pkg::*;

	fifo_status_t in_status;
	fifo_status_t out_status;
	word_t        in_data;
	word_t        out_data;
	logic         in_valid;
	logic         in_re;
	logic         out_we;

	// ----------------------------------------------------------------------
	// host pipe paths
	// ----------------------------------------------------------------------
	pipe_in_path u_pipe_in (
		.okClk      (okClk),
		.i_arst_n   (i_arst_n),
		.i_clear    (i_ctrl.fifo_reset),
		.i_pi_write (i_pi_write),
		.i_pi_data  (i_pi_data),
		.i_re       (in_re),
		.o_rdata    (in_data),
		.o_valid    (in_valid),
		.o_status   (in_status),
		.o_pi_ready (o_pi_ready)
	);

	pipe_out_path u_pipe_out (
		.okClk      (okClk),
		.i_arst_n   (i_arst_n),
		.i_clear    (i_ctrl.fifo_reset),
		.i_we       (out_we),
		.i_wdata    (out_data),
		.i_po_read  (i_po_read),
		.o_po_data  (o_po_data),
		.o_po_valid (o_po_valid),
		.o_status   (out_status),
		.o_po_ready (o_po_ready)
	);

	// port 0 write source is either pipe-in or the engine stream
	port0_mover u_mover (
		.okClk        (okClk),
		.i_arst_n     (i_arst_n),
		.i_ctrl       (i_ctrl),
		.i_in_status  (in_status),
		.i_in_data    (in_data),
		.i_in_valid   (in_valid),
		.o_in_re      (in_re),
		.i_eng_data   (i_eng_data),
		.i_eng_valid  (i_eng_valid),
		.o_eng_re     (o_eng_re),
		.i_out_status (out_status),
		.o_out_we     (out_we),
		.o_out_data   (out_data),
		.o_led        (o_led)
	);

endmodule

// ==== logic/pipe_fifo.sv ====
`timescale 1ns/1ns
`include "cnn_host_defines.svh"

module pipe_fifo #(
	parameter int DEPTH_LIMIT = `CNN_FIFO_SIZE,
	parameter int WIDTH       = `CNN_WORD_W
) (
	input  logic                       okClk,
	input  logic                       i_arst_n,
	input  logic                       i_clear,
	input  logic                       i_we,
	input  logic [WIDTH-1:0]           i_wdata,
	input  logic                       i_re,
	output logic [WIDTH-1:0]           o_rdata,
	output logic                       o_valid,
	output cnn_host_pkg::fifo_status_t o_status
);
	import cnn_host_pkg::*;

	localparam int AW = (DEPTH_LIMIT > 1) ? $clog2(DEPTH_LIMIT) : 1;

	logic [WIDTH-1:0] mem [DEPTH_LIMIT];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	fifo_count_t      count;
	logic             is_full;
	logic             is_empty;
	logic             do_write;
	logic             do_read;

	// pointers wrap at the depth limit, not at a power of two
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH_LIMIT - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign is_full  = (count == fifo_count_t'(DEPTH_LIMIT));
	assign is_empty = (count == '0);
	assign do_write = i_we && !is_full;   // writes while full are dropped
	assign do_read  = i_re && !is_empty;

	// ----------------------------------------------------------------------
	// pointers, count and read strobe
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			o_valid <= 1'b0;
		end else if (i_clear) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			o_valid <= 1'b0;
		end else begin
			if (do_write) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			o_valid <= do_read;                 // data lands one cycle after the read
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // idle or simultaneous push and pop
			endcase
		end
	end

	// storage and registered read data
	always_ff @(posedge okClk) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (do_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

	assign o_status.full  = is_full;
	assign o_status.empty = is_empty;
	assign o_status.count = count;

endmodule

// ==== logic/pipe_in_path.sv ====
`timescale 1ns/1ns
`include "cnn_host_defines.svh"

module pipe_in_path (
	input  logic                       okClk,
	input  logic                       i_arst_n,
	input  logic                       i_clear,
	input  logic                       i_pi_write,
	input  cnn_host_pkg::word_t        i_pi_data,
	input  logic                       i_re,
	output cnn_host_pkg::word_t        o_rdata,
	output logic                       o_valid,
	output cnn_host_pkg::fifo_status_t o_status,
	output logic                       o_pi_ready
);

	// a new host block is accepted only if a whole block plus margin still fits
	localparam int READY_LIMIT = `CNN_FIFO_SIZE - `CNN_BUFFER_HEADROOM - `CNN_BLOCK_SIZE;

	pipe_fifo u_pi_fifo (
		.okClk    (okClk),
		.i_arst_n (i_arst_n),
		.i_clear  (i_clear),
		.i_we     (i_pi_write),   // host write strobe
		.i_wdata  (i_pi_data),
		.i_re     (i_re),         // from the mover
		.o_rdata  (o_rdata),
		.o_valid  (o_valid),
		.o_status (o_status)
	);

	// ----------------------------------------------------------------------
	// block throttle
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pi_ready <= 1'b0;
		end else begin
			o_pi_ready <= (o_status.count <= READY_LIMIT);  // lags the count by one
		end
	end

endmodule

// ==== logic/pipe_out_path.sv ====
`timescale 1ns/1ns
`include "cnn_host_defines.svh"

module pipe_out_path (
	input  logic                       okClk,
	input  logic                       i_arst_n,
	input  logic                       i_clear,
	input  logic                       i_we,
	input  cnn_host_pkg::word_t        i_wdata,
	input  logic                       i_po_read,
	output cnn_host_pkg::word_t        o_po_data,
	output logic                       o_po_valid,
	output cnn_host_pkg::fifo_status_t o_status,
	output logic                       o_po_ready
);

	pipe_fifo u_po_fifo (
		.okClk    (okClk),
		.i_arst_n (i_arst_n),
		.i_clear  (i_clear),
		.i_we     (i_we),         // from the mover
		.i_wdata  (i_wdata),
		.i_re     (i_po_read),    // host read strobe
		.o_rdata  (o_po_data),
		.o_valid  (o_po_valid),
		.o_status (o_status)
	);

	// ----------------------------------------------------------------------
	// block available flag
	// ----------------------------------------------------------------------

	// the host only starts a transfer when a full block can be drained
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_po_ready <= 1'b0;
		end else begin
			o_po_ready <= (o_status.count >= `CNN_BLOCK_SIZE);
		end
	end

endmodule

// ==== logic/port0_mover.sv ====
`timescale 1ns/1ns
`include "cnn_host_defines.svh"

module port0_mover (
	input  logic                       okClk,
	input  logic                       i_arst_n,
	input  cnn_host_pkg::host_ctrl_t   i_ctrl,
	input  cnn_host_pkg::fifo_status_t i_in_status,
	input  cnn_host_pkg::word_t        i_in_data,
	input  logic                       i_in_valid,
	output logic                       o_in_re,
	input  cnn_host_pkg::word_t        i_eng_data,
	input  logic                       i_eng_valid,
	output logic                       o_eng_re,
	input  cnn_host_pkg::fifo_status_t i_out_status,
	output logic                       o_out_we,
	output cnn_host_pkg::word_t        o_out_data,
	output logic [7:0]                 o_led
);
	import cnn_host_pkg::*;

	mover_state_e          state;
	mover_state_e          state_nxt;
	fifo_count_t           in_flight;   // issued reads not yet in the pipe-out count
	logic [`CNN_COUNT_W:0] committed;
	logic                  space_ok;
	logic                  issue;

	// ----------------------------------------------------------------------
	// source select
	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt = MV_IDLE;
		if (i_ctrl.move_en && i_ctrl.engine_sel) begin
			state_nxt = MV_ENGINE;
		end else if (i_ctrl.move_en && i_ctrl.write_en) begin
			state_nxt = MV_PIPE;
		end
	end

	assign committed = {1'b0, i_out_status.count} + {1'b0, in_flight};
	assign space_ok  = (committed < `CNN_FIFO_SIZE);  // back-pressure from pipe-out

	// at most one read per cycle; an engine read waits while pipe data lands
	assign o_in_re  = (state == MV_PIPE) && !i_in_status.empty && space_ok &&
	                  !i_ctrl.fifo_reset;
	assign o_eng_re = (state == MV_ENGINE) && i_eng_valid && !i_in_valid && space_ok &&
	                  !i_ctrl.fifo_reset;
	assign issue    = o_in_re || o_eng_re;

	// ----------------------------------------------------------------------
	// state, write strobe and in-flight tally
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= MV_IDLE;
			in_flight <= '0;
			o_out_we  <= 1'b0;
		end else if (i_ctrl.fifo_reset) begin
			state     <= MV_IDLE;
			in_flight <= '0;
			o_out_we  <= 1'b0;
		end else begin
			state    <= state_nxt;
			o_out_we <= o_eng_re || i_in_valid;
			case ({issue, o_out_we})
				2'b10:   in_flight <= in_flight + 1'b1;
				2'b01:   in_flight <= in_flight - 1'b1;  // now counted by pipe-out
				default: in_flight <= in_flight;
			endcase
		end
	end

	// one register stage keeps the engine word timing and source order
	always_ff @(posedge okClk) begin
		if (i_in_valid) begin
			o_out_data <= i_in_data;
		end else if (o_eng_re) begin
			o_out_data <= i_eng_data;
		end
	end

	// board LEDs are active low
	assign o_led = ~{i_in_status.full, i_in_status.empty,
	                 i_out_status.full, i_out_status.empty,
	                 state, i_ctrl.engine_sel, i_ctrl.move_en};

endmodule

// ==== tb/tb_cnn_host.sv ====
`timescale 1ns/1ns
`include "cnn_host_defines.svh"

module tb_cnn_host;
	import cnn_host_pkg::*;

	localparam int RESET_CYCLES  = 16;
	localparam int SETTLE_CYCLES = 6;   // 3 cycle move, ready register, margin
	localparam int ENG_SLACK     = 32;  // cycles allowed beyond one word per cycle
	localparam int NUM_ROWS      = 14;

	// control wire, {spare, engine_sel, fifo_reset, write_en, move_en}
	localparam host_ctrl_t CTRL_IDLE = 5'b00000;
	localparam host_ctrl_t CTRL_PIPE = 5'b00011;
	localparam host_ctrl_t CTRL_HOLD = 5'b00010;
	localparam host_ctrl_t CTRL_ENG  = 5'b01001;
	localparam host_ctrl_t CTRL_RST  = 5'b00100;

	typedef enum logic [1:0] {ROW_IDLE, ROW_WRITE, ROW_READ, ROW_ENGINE} row_kind_e;

	typedef struct packed {
		host_ctrl_t  ctrl;
		row_kind_e   kind;
		logic [10:0] words;
		logic        pi_ready;  // expected once settled
		logic        po_ready;
	} row_t;

	logic       okClk;
	logic       i_arst_n;
	host_ctrl_t i_ctrl;
	logic       i_pi_write;
	word_t      i_pi_data;
	logic       o_pi_ready;
	logic       i_po_read;
	word_t      o_po_data;
	logic       o_po_valid;
	logic       o_po_ready;
	word_t      i_eng_data;
	logic       i_eng_valid;
	logic       o_eng_re;
	logic [7:0] o_led;
	logic       settled;
	logic       exp_pi_ready;
	logic       exp_po_ready;
	int         data_errors;
	int         level_errors;
	int         timeouts = 0;
	integer     seed     = 32'h83e0;
	row_t       rows [NUM_ROWS];

	cnn_host_top u_cnn_host_top (
		.okClk(okClk), .i_arst_n(i_arst_n), .i_ctrl(i_ctrl),
		.i_pi_write(i_pi_write), .i_pi_data(i_pi_data), .o_pi_ready(o_pi_ready),
		.i_po_read(i_po_read), .o_po_data(o_po_data), .o_po_valid(o_po_valid),
		.o_po_ready(o_po_ready), .i_eng_data(i_eng_data), .i_eng_valid(i_eng_valid),
		.o_eng_re(o_eng_re), .o_led(o_led)
	);

	tb_cnn_host_checker u_checker (
		.okClk(okClk), .i_arst_n(i_arst_n), .i_ctrl(i_ctrl),
		.i_pi_write(i_pi_write), .i_pi_data(i_pi_data), .i_pi_ready(o_pi_ready),
		.i_po_read(i_po_read), .i_po_data(o_po_data), .i_po_valid(o_po_valid),
		.i_po_ready(o_po_ready), .i_eng_data(i_eng_data), .i_eng_valid(i_eng_valid),
		.i_eng_re(o_eng_re), .i_led(o_led), .i_settled(settled),
		.i_exp_pi_ready(exp_pi_ready), .i_exp_po_ready(exp_po_ready),
		.o_data_errors(data_errors), .o_level_errors(level_errors)
	);

	initial begin
		okClk = 1'b0;
		forever #20 okClk = ~okClk;
	end

	// ----------------------------------------------------------------------
	// stimulus table: control, action, words, pipe-in ready, pipe-out ready
	// ----------------------------------------------------------------------
	task automatic load_rows();
		rows[0]  = '{CTRL_IDLE, ROW_IDLE,   11'd0,    1'b1, 1'b0};  // state after reset
		rows[1]  = '{CTRL_PIPE, ROW_WRITE,  11'd40,   1'b1, 1'b0};
		rows[2]  = '{CTRL_PIPE, ROW_READ,   11'd40,   1'b1, 1'b0};  // loopback
		rows[3]  = '{CTRL_PIPE, ROW_WRITE,  11'd200,  1'b1, 1'b1};
		rows[4]  = '{CTRL_PIPE, ROW_READ,   11'd200,  1'b1, 1'b0};
		rows[5]  = '{CTRL_HOLD, ROW_WRITE,  11'd900,  1'b0, 1'b0};  // past 875 words
		rows[6]  = '{CTRL_RST,  ROW_IDLE,   11'd0,    1'b1, 1'b0};
		rows[7]  = '{CTRL_PIPE, ROW_WRITE,  11'd1030, 1'b1, 1'b1};  // pipe-out full
		rows[8]  = '{CTRL_PIPE, ROW_READ,   11'd1030, 1'b1, 1'b0};
		rows[9]  = '{CTRL_HOLD, ROW_WRITE,  11'd30,   1'b1, 1'b0};
		rows[10] = '{CTRL_ENG,  ROW_ENGINE, 11'd150,  1'b1, 1'b1};  // pipe-in left alone
		rows[11] = '{CTRL_ENG,  ROW_READ,   11'd100,  1'b1, 1'b0};  // 50 words stay in pipe-out
		rows[12] = '{CTRL_RST,  ROW_IDLE,   11'd0,    1'b1, 1'b0};
		rows[13] = '{CTRL_IDLE, ROW_READ,   11'd4,    1'b1, 1'b0};  // reads of empty FIFO
	endtask

	task automatic end_run();
		$display("Summary: %0d data errors, %0d level errors, %0d timeouts",
		         data_errors, level_errors, timeouts);
		if ((data_errors + level_errors + timeouts) == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	task automatic push_words(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge okClk);
			i_pi_write <= 1'b1;
			i_pi_data  <= $random(seed);
		end
		@(posedge okClk);
		i_pi_write <= 1'b0;
	endtask

	task automatic pop_words(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge okClk);
			i_po_read <= 1'b1;
		end
		@(posedge okClk);
		i_po_read <= 1'b0;
	endtask

	// engine holds each word until o_eng_re takes it
	task automatic feed_engine(input int n);
		int left;
		int waited;
		left   = n;
		waited = 0;
		@(posedge okClk);
		i_eng_valid <= 1'b1;
		i_eng_data  <= $random(seed);
		while ((left > 0) && (waited < n + ENG_SLACK)) begin
			@(posedge okClk);
			waited++;
			if (o_eng_re) begin
				left--;
				if (left > 0) begin
					i_eng_data <= $random(seed);
				end else begin
					i_eng_valid <= 1'b0;
				end
			end
		end
		if (left > 0) begin
			$display("Timeout at %0t ns: engine stream stalled, %0d words left", $time, left);
			timeouts++;
			end_run();
		end
	endtask

	task automatic apply_row(input row_t row);
		@(posedge okClk);
		i_ctrl <= row.ctrl;
		if (row.ctrl.fifo_reset) begin        // one cycle pulse
			@(posedge okClk);
			i_ctrl <= CTRL_IDLE;
		end
		case (row.kind)
			ROW_WRITE:  push_words(row.words);
			ROW_READ:   pop_words(row.words);
			ROW_ENGINE: feed_engine(row.words);
			default:    ;
		endcase
		for (int i = 0; i < SETTLE_CYCLES; i++) begin
			@(posedge okClk);
		end
		settled      <= 1'b1;
		exp_pi_ready <= row.pi_ready;
		exp_po_ready <= row.po_ready;
		@(posedge okClk);
		settled <= 1'b0;
	endtask

	initial begin
		i_arst_n     = 1'b0;
		i_ctrl       = CTRL_IDLE;
		i_pi_write   = 1'b0;
		i_pi_data    = '0;
		i_po_read    = 1'b0;
		i_eng_data   = '0;
		i_eng_valid  = 1'b0;
		settled      = 1'b0;
		exp_pi_ready = 1'b0;
		exp_po_ready = 1'b0;
		load_rows();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge okClk);
		end
		i_arst_n <= 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(rows[r]);
		end
		end_run();
	end

endmodule

// ==== tb/tb_cnn_host_checker.sv ====
`timescale 1ns/1ns
`include "cnn_host_defines.svh"

module tb_cnn_host_checker (
	input  logic                     okClk,
	input  logic                     i_arst_n,
	input  cnn_host_pkg::host_ctrl_t i_ctrl,
	input  logic                     i_pi_write,
	input  cnn_host_pkg::word_t      i_pi_data,
	input  logic                     i_pi_ready,
	input  logic                     i_po_read,
	input  cnn_host_pkg::word_t      i_po_data,
	input  logic                     i_po_valid,
	input  logic                     i_po_ready,
	input  cnn_host_pkg::word_t      i_eng_data,
	input  logic                     i_eng_valid,
	input  logic                     i_eng_re,
	input  logic [7:0]               i_led,
	input  logic                     i_settled,
	input  logic                     i_exp_pi_ready,
	input  logic                     i_exp_po_ready,
	output int                       o_data_errors,
	output int                       o_level_errors
);
	import cnn_host_pkg::*;

	localparam int READY_LIMIT = `CNN_FIFO_SIZE - `CNN_BUFFER_HEADROOM - `CNN_BLOCK_SIZE;

	word_t      pi_q [$];     // words held by pipe-in
	word_t      po_q [$];     // words owed to pipe-out, in flight included
	word_t      exp_word;
	logic       exp_valid;
	logic [1:0] thr_pending;  // pipe-in ready checks, two cycles deep
	logic [1:0] thr_expect;
	int         data_errors  = 0;
	int         level_errors = 0;

	assign o_data_errors  = data_errors;
	assign o_level_errors = level_errors;

	task automatic report_mismatch(input bit is_data, input string name,
	                               input logic [31:0] exp_val, input logic [31:0] got_val);
		$display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp_val, got_val);
		if (is_data) begin
			data_errors++;
		end else begin
			level_errors++;
		end
	endtask

	// active low LED byte for the modelled FIFO levels and the selected source
	function automatic logic [7:0] expected_led();
		mover_state_e st;
		st = MV_IDLE;
		if (i_ctrl.move_en && i_ctrl.engine_sel) begin
			st = MV_ENGINE;
		end else if (i_ctrl.move_en && i_ctrl.write_en) begin
			st = MV_PIPE;
		end
		return ~{pi_q.size() == `CNN_FIFO_SIZE, pi_q.size() == 0,
		         po_q.size() == `CNN_FIFO_SIZE, po_q.size() == 0,
		         st, i_ctrl.engine_sel, i_ctrl.move_en};
	endfunction

	// ----------------------------------------------------------------------
	// queue models, sampled on the rising edge
	// ----------------------------------------------------------------------
	always @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pi_q.delete();
			po_q.delete();
			exp_valid   = 1'b0;
			thr_pending = 2'b00;
			thr_expect  = 2'b00;
		end else begin
			if (exp_valid) begin                       // pop from the previous cycle
				if (i_po_valid !== 1'b1) begin
					report_mismatch(1'b1, "o_po_valid", 1, i_po_valid);
				end else if (i_po_data !== exp_word) begin
					report_mismatch(1'b1, "o_po_data", exp_word, i_po_data);
				end
			end else if (i_po_valid !== 1'b0) begin
				report_mismatch(1'b1, "o_po_valid", 0, i_po_valid);
			end
			exp_valid = 1'b0;
			if (thr_pending[1] && (i_pi_ready !== thr_expect[1])) begin
				report_mismatch(1'b0, "o_pi_ready", thr_expect[1], i_pi_ready);
			end
			thr_pending = {thr_pending[0], 1'b0};
			thr_expect  = {thr_expect[0], 1'b0};
			if (i_settled) begin
				if (i_pi_ready !== i_exp_pi_ready) begin
					report_mismatch(1'b0, "o_pi_ready", i_exp_pi_ready, i_pi_ready);
				end
				if (i_po_ready !== i_exp_po_ready) begin
					report_mismatch(1'b0, "o_po_ready", i_exp_po_ready, i_po_ready);
				end
				if (i_po_ready !== (po_q.size() >= `CNN_BLOCK_SIZE)) begin
					report_mismatch(1'b0, "o_po_ready", po_q.size() >= `CNN_BLOCK_SIZE,
					                i_po_ready);
				end
				if (i_led !== expected_led()) begin
					report_mismatch(1'b0, "o_led", expected_led(), i_led);
				end
			end
			if (i_ctrl.fifo_reset) begin               // both FIFOs drop their words
				pi_q.delete();
				po_q.delete();
				thr_pending = 2'b00;
			end else begin
				if (i_po_read && (po_q.size() > 0)) begin
					exp_valid = 1'b1;
					exp_word  = po_q.pop_front();
				end
				if (i_pi_write && (pi_q.size() < `CNN_FIFO_SIZE)) begin
					pi_q.push_back(i_pi_data);
					if (!i_ctrl.move_en) begin         // count is exact only while nothing moves
						thr_pending[0] = 1'b1;
						thr_expect[0]  = (pi_q.size() <= READY_LIMIT);
					end
				end
				if (i_eng_re) begin
					if (i_eng_valid !== 1'b1) begin    // strobe with no engine word held
						report_mismatch(1'b0, "o_eng_re", 0, i_eng_re);
					end else begin
						po_q.push_back(i_eng_data);
					end
				end
				if (i_ctrl.move_en && i_ctrl.write_en && !i_ctrl.engine_sel) begin
					while ((pi_q.size() > 0) && (po_q.size() < `CNN_FIFO_SIZE)) begin
						po_q.push_back(pi_q.pop_front());
					end
				end
			end
		end
	end

endmodule
